//--- logic/vrc_bus_pkg.sv
package vrc_bus_pkg;

	// cpu side of the cartridge edge.
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// ppu side, pattern tables plus nametables.
	typedef logic [13:0] ppu_addr_t;

	// rom and ram addresses after banking.
	typedef logic [20:0] prg_addr_t;
	typedef logic [17:0] chr_addr_t;

	// one bank register as written by the cpu.
	typedef logic [7:0]  bank_t;

	// mapper number from the cartridge config.
	typedef logic [7:0]  map_idx_t;

	// expansion audio.
	typedef logic [3:0]  vol_t;
	typedef logic [15:0] snd_t;

endpackage

//--- logic/vrc_regmap_pkg.sv
package vrc_regmap_pkg;

	// ------------------------------
	// register addresses
	// ------------------------------
	// prg registers decode on a15..a12 only.
	localparam vrc_bus_pkg::cpu_addr_t reg_prg16     = 16'h8000;
	localparam vrc_bus_pkg::cpu_addr_t reg_prg8      = 16'hC000;
	localparam vrc_bus_pkg::cpu_addr_t reg_mir       = 16'hB003;
	// chr windows decode on a15..a2.
	localparam vrc_bus_pkg::cpu_addr_t reg_chr_lo    = 16'hD000;
	localparam vrc_bus_pkg::cpu_addr_t reg_chr_hi    = 16'hE000;
	localparam vrc_bus_pkg::cpu_addr_t reg_irq_latch = 16'hF000;
	localparam vrc_bus_pkg::cpu_addr_t reg_irq_ctrl  = 16'hF001;
	localparam vrc_bus_pkg::cpu_addr_t reg_irq_ack   = 16'hF002;
	localparam vrc_bus_pkg::cpu_addr_t reg_pulse1    = 16'h9000;
	localparam vrc_bus_pkg::cpu_addr_t reg_pulse2    = 16'hA000;

	// the 8k bank at c000 comes up on page 1.
	localparam vrc_bus_pkg::bank_t prg8_rst = 8'd1;

	// boards with a0 and a1 crossed.
	localparam vrc_bus_pkg::map_idx_t map_swapped = 8'd26;

	// nametable mirroring, as written to b003 bits 3..2.
	typedef enum logic [1:0] {
		mir_vert,
		mir_horz,
		mir_one_lo,
		mir_one_hi
	} mir_mode_t;

	// irq control register bits.
	localparam int irq_ctrl_a = 0;
	localparam int irq_ctrl_e = 1;

endpackage

//--- logic/vrc_reg_decode.sv
`timescale 1ns/1ps

module vrc_reg_decode (
	input  logic                      m2,
	input  logic                      arst_n,
	input  vrc_bus_pkg::map_idx_t     map_idx,
	input  vrc_bus_pkg::cpu_addr_t    cpu_addr,
	input  vrc_bus_pkg::cpu_data_t    cpu_data,
	input  logic                      cpu_rw,
	output vrc_bus_pkg::cpu_addr_t    reg_addr,
	output vrc_bus_pkg::bank_t        prg_bank0,
	output vrc_bus_pkg::bank_t        prg_bank1,
	output vrc_bus_pkg::bank_t        chr_bank [0:7],
	output vrc_regmap_pkg::mir_mode_t mir
);
	import vrc_bus_pkg::*;
	import vrc_regmap_pkg::*;

	cpu_addr_t swapped_addr;
	logic      wr;

	// mapper 26 boards route a0 and a1 crossed into the chip.
	assign swapped_addr = {cpu_addr[15:2], cpu_addr[0], cpu_addr[1]};
	assign reg_addr     = (map_idx == map_swapped) ? swapped_addr : cpu_addr;

	assign wr = !cpu_rw;

	// ------------------------------
	// prg banks and mirroring
	// ------------------------------
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prg_bank0 <= '0;
			prg_bank1 <= prg8_rst;
			mir       <= mir_vert;
		end
		else if (wr)
		begin
			// whole 4k window selects the prg registers.
			if (reg_addr[15:12] == reg_prg16[15:12])
			begin
				prg_bank0 <= cpu_data;
			end
			if (reg_addr[15:12] == reg_prg8[15:12])
			begin
				prg_bank1 <= cpu_data;
			end
			if (reg_addr == reg_mir)
			begin
				mir <= mir_mode_t'(cpu_data[3:2]);
			end
		end
	end

	// ------------------------------
	// chr bank file
	// ------------------------------
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 8; i++)
			begin
				chr_bank[i] <= '0;
			end
		end
		else if (wr)
		begin
			// d00x fills banks 0..3, e00x fills 4..7.
			if (reg_addr[15:2] == reg_chr_lo[15:2])
			begin
				chr_bank[{1'b0, reg_addr[1:0]}] <= cpu_data;
			end
			if (reg_addr[15:2] == reg_chr_hi[15:2])
			begin
				chr_bank[{1'b1, reg_addr[1:0]}] <= cpu_data;
			end
		end
	end

	// every register block downstream keys off a clean rw.
	a_rw_known: assert property (@(negedge m2) disable iff (!arst_n)
		!$isunknown(cpu_rw));

endmodule

//--- logic/vrc_addr_map.sv
`timescale 1ns/1ps

module vrc_addr_map (
	input  vrc_bus_pkg::cpu_addr_t    cpu_addr,
	input  vrc_bus_pkg::ppu_addr_t    ppu_addr,
	input  vrc_bus_pkg::bank_t        prg_bank0,
	input  vrc_bus_pkg::bank_t        prg_bank1,
	input  vrc_bus_pkg::bank_t        chr_bank [0:7],
	input  vrc_regmap_pkg::mir_mode_t mir,
	input  logic                      cpu_rw,
	output vrc_bus_pkg::prg_addr_t    prg_addr,
	output logic                      prg_ce,
	output logic                      srm_ce,
	output logic                      srm_we,
	output vrc_bus_pkg::chr_addr_t    chr_addr,
	output logic                      ciram_a10,
	output logic                      ciram_ce
);
	import vrc_bus_pkg::*;
	import vrc_regmap_pkg::*;

	bank_t prg_page;
	bank_t chr_page;

	// ------------------------------
	// cpu side
	// ------------------------------
	always_comb
	begin
		if (cpu_addr[15:13] == reg_prg8[15:13])
		begin
			prg_page = prg_bank1;
		end
		else if (cpu_addr[15:13] == 3'b111)
		begin
			// fixed to the last page.
			prg_page = '1;
		end
		else
		begin
			// 16k bank, a13 picks the half.
			prg_page = {prg_bank0[6:0], cpu_addr[13]};
		end
	end

	assign prg_addr = {prg_page, cpu_addr[12:0]};
	assign prg_ce   = cpu_addr[15];

	// work ram at 6000..7fff.
	assign srm_ce = (cpu_addr[15:13] == 3'b011);
	assign srm_we = !cpu_rw;

	// ------------------------------
	// ppu side
	// ------------------------------
	assign chr_page = chr_bank[ppu_addr[12:10]];
	assign chr_addr = {chr_page, ppu_addr[9:0]};
	assign ciram_ce = !ppu_addr[13];

	always_comb
	begin
		unique case (mir)
			mir_vert:   ciram_a10 = ppu_addr[10];
			mir_horz:   ciram_a10 = ppu_addr[11];
			mir_one_lo: ciram_a10 = 1'b0;
			mir_one_hi: ciram_a10 = 1'b1;
		endcase
	end

endmodule

//--- logic/vrc_irq.sv
`timescale 1ns/1ps

module vrc_irq (
	input  logic                   m2,
	input  logic                   arst_n,
	input  vrc_bus_pkg::cpu_addr_t reg_addr,
	input  vrc_bus_pkg::cpu_data_t cpu_data,
	input  logic                   cpu_rw,
	output logic                   irq
);
	import vrc_bus_pkg::*;
	import vrc_regmap_pkg::*;

	cpu_data_t  irq_latch;
	logic [7:0] irq_cnt;
	logic       irq_e;
	logic       irq_a;
	logic       wr_latch;
	logic       wr_ctrl;
	logic       wr_ack;

	assign wr_latch = !cpu_rw && (reg_addr == reg_irq_latch);
	assign wr_ctrl  = !cpu_rw && (reg_addr == reg_irq_ctrl);
	assign wr_ack   = !cpu_rw && (reg_addr == reg_irq_ack);

	// reload value.
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			irq_latch <= '0;
		end
		else if (wr_latch)
		begin
			irq_latch <= cpu_data;
		end
	end

	// ------------------------------
	// control, counter, pending flag
	// ------------------------------
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			irq_e   <= 1'b0;
			irq_a   <= 1'b0;
			irq_cnt <= '0;
			irq     <= 1'b0;
		end
		else
		begin
			if (wr_ctrl)
			begin
				irq_a <= cpu_data[irq_ctrl_a];
				irq_e <= cpu_data[irq_ctrl_e];
				irq   <= 1'b0;
				if (cpu_data[irq_ctrl_e])
				begin
					irq_cnt <= irq_latch;
				end
			end
			else if (irq_e)
			begin
				// counter steps once per cpu cycle.
				if (irq_cnt == 8'hFF)
				begin
					irq_cnt <= irq_latch;
					irq     <= 1'b1;
				end
				else
				begin
					irq_cnt <= irq_cnt + 8'd1;
				end
			end
			// ack beats a wrap on the same cycle.
			if (wr_ack)
			begin
				irq   <= 1'b0;
				irq_e <= irq_a;
			end
		end
	end

	a_irq_needs_e: assert property (@(negedge m2) disable iff (!arst_n)
		$rose(irq) |-> $past(irq_e));

endmodule

//--- logic/vrc_pulse.sv
`timescale 1ns/1ps

module vrc_pulse #(
	parameter vrc_bus_pkg::cpu_addr_t base = vrc_regmap_pkg::reg_pulse1
) (
	input  logic                   m2,
	input  logic                   arst_n,
	input  vrc_bus_pkg::cpu_addr_t reg_addr,
	input  vrc_bus_pkg::cpu_data_t cpu_data,
	input  logic                   cpu_rw,
	output vrc_bus_pkg::vol_t      vol
);
	import vrc_bus_pkg::*;

	logic        mode;
	logic [2:0]  duty;
	vol_t        volume;
	logic [11:0] freq;
	logic        enable;
	logic [11:0] div;
	logic [3:0]  step;
	logic        wr_win;

	assign wr_win = !cpu_rw && (reg_addr[15:2] == base[15:2]);

	// ------------------------------
	// channel registers
	// ------------------------------
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mode   <= 1'b0;
			duty   <= '0;
			volume <= '0;
			freq   <= '0;
			enable <= 1'b0;
		end
		else if (wr_win)
		begin
			if (reg_addr[1:0] == 2'd0)
			begin
				mode   <= cpu_data[7];
				duty   <= cpu_data[6:4];
				volume <= cpu_data[3:0];
			end
			if (reg_addr[1:0] == 2'd1)
			begin
				freq[7:0] <= cpu_data;
			end
			if (reg_addr[1:0] == 2'd2)
			begin
				enable     <= cpu_data[7];
				freq[11:8] <= cpu_data[3:0];
			end
		end
	end

	// divider and 16-step duty sequencer.
	always_ff @(negedge m2 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div  <= '0;
			step <= '0;
		end
		else if (!enable)
		begin
			div  <= freq;
			step <= '0;
		end
		else if (div == '0)
		begin
			div  <= freq;
			step <= step + 4'd1;
		end
		else
		begin
			div <= div - 12'd1;
		end
	end

	// mode bit forces a constant level
	assign vol = (enable && (mode || (step <= {1'b0, duty}))) ? volume : '0;

endmodule

//--- logic/vrc_mapper.sv
`timescale 1ns/1ps

module vrc_mapper (
	input  logic                   m2,
	input  logic                   arst_n,
	input  vrc_bus_pkg::map_idx_t  map_idx,
	input  vrc_bus_pkg::cpu_addr_t cpu_addr,
	input  vrc_bus_pkg::cpu_data_t cpu_data,
	input  logic                   cpu_rw,
	input  vrc_bus_pkg::ppu_addr_t ppu_addr,
	output vrc_bus_pkg::prg_addr_t prg_addr,
	output logic                   prg_ce,
	output logic                   srm_ce,
	output logic                   srm_we,
	output vrc_bus_pkg::chr_addr_t chr_addr,
	output logic                   ciram_a10,
	output logic                   ciram_ce,
	output logic                   irq,
	output vrc_bus_pkg::snd_t      snd
);
	import vrc_bus_pkg::*;
	import vrc_regmap_pkg::*;

	cpu_addr_t  reg_addr;
	bank_t      prg_bank0;
	bank_t      prg_bank1;
	bank_t      chr_bank [0:7];
	mir_mode_t  mir;
	vol_t       vol1;
	vol_t       vol2;
	logic [4:0] vol_sum;

	// ------------------------------
	// register file and decode
	// ------------------------------
	vrc_reg_decode u_decode (
		.m2        (m2),
		.arst_n    (arst_n),
		.map_idx   (map_idx),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data),
		.cpu_rw    (cpu_rw),
		.reg_addr  (reg_addr),
		.prg_bank0 (prg_bank0),
		.prg_bank1 (prg_bank1),
		.chr_bank  (chr_bank),
		.mir       (mir)
	);

	vrc_addr_map u_map (
		.cpu_addr  (cpu_addr),
		.ppu_addr  (ppu_addr),
		.prg_bank0 (prg_bank0),
		.prg_bank1 (prg_bank1),
		.chr_bank  (chr_bank),
		.mir       (mir),
		.cpu_rw    (cpu_rw),
		.prg_addr  (prg_addr),
		.prg_ce    (prg_ce),
		.srm_ce    (srm_ce),
		.srm_we    (srm_we),
		.chr_addr  (chr_addr),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

	vrc_irq u_irq (
		.m2       (m2),
		.arst_n   (arst_n),
		.reg_addr (reg_addr),
		.cpu_data (cpu_data),
		.cpu_rw   (cpu_rw),
		.irq      (irq)
	);

	// ------------------------------
	// expansion sound
	// ------------------------------
	vrc_pulse #(.base(reg_pulse1)) u_pulse1 (
		.m2       (m2),
		.arst_n   (arst_n),
		.reg_addr (reg_addr),
		.cpu_data (cpu_data),
		.cpu_rw   (cpu_rw),
		.vol      (vol1)
	);

	vrc_pulse #(.base(reg_pulse2)) u_pulse2 (
		.m2       (m2),
		.arst_n   (arst_n),
		.reg_addr (reg_addr),
		.cpu_data (cpu_data),
		.cpu_rw   (cpu_rw),
		.vol      (vol2)
	);

	// mix is left-justified in the 16-bit sample.
	assign vol_sum = {1'b0, vol1} + {1'b0, vol2};
	assign snd     = {vol_sum, 11'd0};

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic m2,
	output logic arst_n
);

	// 100 ns cpu cycle.
	initial
	begin
		m2 = 1'b0;
		forever #50 m2 = ~m2;
	end

	// reset held through the first 16 cycles.
	initial
	begin
		arst_n = 1'b0;
		repeat (16) @(posedge m2);
		arst_n <= 1'b1;
	end

endmodule

//--- testbench/vrc_tb.sv
`timescale 1ns/1ps

module vrc_tb;
	import vrc_bus_pkg::*;
	import vrc_regmap_pkg::*;

	logic      m2;
	logic      arst_n;
	map_idx_t  map_idx;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_data;
	logic      cpu_rw;
	ppu_addr_t ppu_addr;
	prg_addr_t prg_addr;
	logic      prg_ce;
	logic      srm_ce;
	logic      srm_we;
	chr_addr_t chr_addr;
	logic      ciram_a10;
	logic      ciram_ce;
	logic      irq;
	snd_t      snd;

	// register state as the cpu has written it.
	bank_t     m_prg0;
	bank_t     m_prg1;
	bank_t     m_chr [0:7];
	mir_mode_t m_mir;
	logic      m_mode [0:1];
	vol_t      m_vol [0:1];
	logic      m_en [0:1];

	logic chk_on;
	int   errors;
	int   checks;
	int   tests_run;
	int   tests_failed;

	tb_clock clk0 (.m2(m2), .arst_n(arst_n));

	vrc_mapper dut0 (
		.m2        (m2),
		.arst_n    (arst_n),
		.map_idx   (map_idx),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data),
		.cpu_rw    (cpu_rw),
		.ppu_addr  (ppu_addr),
		.prg_addr  (prg_addr),
		.prg_ce    (prg_ce),
		.srm_ce    (srm_ce),
		.srm_we    (srm_we),
		.chr_addr  (chr_addr),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.irq       (irq),
		.snd       (snd)
	);

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic prg_addr_t ref_prg(cpu_addr_t a, bank_t b0, bank_t b1);
		if (a[15:13] == 3'b110)
			return {b1, a[12:0]};
		if (a[15:13] == 3'b111)
			return {8'hFF, a[12:0]};
		return {b0[6:0], a[13], a[12:0]};
	endfunction

	function automatic chr_addr_t ref_chr(ppu_addr_t p);
		return {m_chr[p[12:10]], p[9:0]};
	endfunction

	function automatic logic ref_a10(ppu_addr_t p, mir_mode_t m);
		case (m)
			mir_vert:   return p[10];
			mir_horz:   return p[11];
			mir_one_lo: return 1'b0;
			default:    return 1'b1;
		endcase
	endfunction

	// only constant-level channels are modeled.
	function automatic snd_t ref_snd();
		logic [4:0] sum;
		sum = 5'd0;
		if (m_en[0] && m_mode[0])
			sum = sum + {1'b0, m_vol[0]};
		if (m_en[1] && m_mode[1])
			sum = sum + {1'b0, m_vol[1]};
		return {sum, 11'd0};
	endfunction

	task model_write(cpu_addr_t a, cpu_data_t d);
		cpu_addr_t r;
		logic      c;
		// mapper 26 boards cross a0 and a1.
		r = (map_idx == map_swapped) ? {a[15:2], a[0], a[1]} : a;
		c = (r[15:12] == 4'hA);
		case (r[15:12])
			4'h8: m_prg0 <= d;
			4'hC: m_prg1 <= d;
			4'hB:
				if (r == reg_mir)
					m_mir <= mir_mode_t'(d[3:2]);
			4'hD:
				if (r[11:2] == 10'h000)
					m_chr[{1'b0, r[1:0]}] <= d;
			4'hE:
				if (r[11:2] == 10'h000)
					m_chr[{1'b1, r[1:0]}] <= d;
			4'h9, 4'hA:
			begin
				if (r[11:0] == 12'h000)
				begin
					m_mode[c] <= d[7];
					m_vol[c]  <= d[3:0];
				end
				else if (r[11:0] == 12'h002)
					m_en[c] <= d[7];
			end
			default: ;
		endcase
	endtask

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_prg(string name, prg_addr_t got, prg_addr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_chr(string name, chr_addr_t got, chr_addr_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_snd(string name, snd_t got, snd_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_edge(string name, int got, int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// outputs settle between edges, so they are read at the rising edge.
	always @(posedge m2)
	begin
		if (chk_on)
		begin
			if (cpu_addr[15])
				check_prg("prg_addr", prg_addr, ref_prg(cpu_addr, m_prg0, m_prg1));
			check_bit("prg_ce", prg_ce, cpu_addr[15]);
			check_bit("srm_ce", srm_ce, cpu_addr[15:13] == 3'b011);
			check_bit("srm_we", srm_we, !cpu_rw);
			check_chr("chr_addr", chr_addr, ref_chr(ppu_addr));
			check_bit("ciram_a10", ciram_a10, ref_a10(ppu_addr, m_mir));
			check_bit("ciram_ce", ciram_ce, !ppu_addr[13]);
			check_snd("snd", snd, ref_snd());
		end
	end

	// ------------------------------
	// bus tasks
	// ------------------------------
	task automatic bus_cycle(cpu_addr_t a, cpu_data_t d, logic rw);
		@(posedge m2);
		cpu_addr <= a;
		cpu_data <= d;
		cpu_rw   <= rw;
		if (!rw)
			model_write(a, d);
	endtask

	// one write, then rw back high so it is taken only once.
	task automatic write_reg(cpu_addr_t a, cpu_data_t d);
		bus_cycle(a, d, 1'b0);
		@(posedge m2);
		cpu_rw <= 1'b1;
	endtask

	task automatic idle(int n);
		repeat (n) bus_cycle(cpu_addr, cpu_data, 1'b1);
	endtask

	task automatic drive_ppu(ppu_addr_t p);
		@(posedge m2);
		ppu_addr <= p;
	endtask

	task automatic set_mapper(map_idx_t m);
		@(posedge m2);
		map_idx <= m;
		cpu_rw  <= 1'b1;
	endtask

	task automatic end_test(string name, int err_before);
		@(posedge m2);
		@(negedge m2);
		tests_run++;
		if (errors == err_before)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
		end
	endtask

	initial
	begin
		int        e0;
		int        n;
		int        k;
		cpu_data_t latch;
		vol_t      v1;
		vol_t      v2;
		logic [10:0] r;
		logic [2:0]  sel;

		void'($urandom(36629));
		map_idx  = 8'd24;
		cpu_addr = 16'h8000;
		cpu_data = 8'h00;
		cpu_rw   = 1'b1;
		ppu_addr = '0;
		chk_on   = 1'b0;
		errors   = 0;
		checks   = 0;
		tests_run    = 0;
		tests_failed = 0;
		m_prg0 = 8'd0;
		m_prg1 = 8'd1;
		m_chr  = '{default: '0};
		m_mir  = mir_vert;
		m_mode = '{default: 1'b0};
		m_vol  = '{default: '0};
		m_en   = '{default: 1'b0};

		n = 0;
		while (arst_n !== 1'b1 && n < 40)
		begin
			@(posedge m2);
			n++;
		end
		if (arst_n !== 1'b1)
		begin
			$display("reset was never released");
			$display("SOME TESTS FAILED");
			$finish;
		end
		else
		begin
			chk_on <= 1'b1;

			// reset banks first, then random prg writes and work ram.
			e0 = errors;
			bus_cycle(16'h8123, 8'h00, 1'b1);
			@(posedge m2);
			check_prg("prg_addr", prg_addr, 21'h000123);
			check_bit("irq", irq, 1'b0);
			bus_cycle(16'hC123, 8'h00, 1'b1);
			@(posedge m2);
			check_prg("prg_addr", prg_addr, 21'h002123);
			bus_cycle(16'hE123, 8'h00, 1'b1);
			@(posedge m2);
			check_prg("prg_addr", prg_addr, 21'h1FE123);
			repeat (6)
			begin
				write_reg({4'h8, 12'($urandom)}, 8'($urandom));
				write_reg({4'hC, 12'($urandom)}, 8'($urandom));
				repeat (12) bus_cycle({1'b1, 15'($urandom)}, 8'h00, 1'b1);
			end
			repeat (16) bus_cycle({3'b011, 13'($urandom)}, 8'($urandom), 1'($urandom));
			bus_cycle(16'h8000, 8'h00, 1'b1);
			end_test("prg banks and work ram", e0);

			// chr banks, straight lines and then a0/a1 crossed.
			e0 = errors;
			set_mapper(8'd24);
			repeat (2)
			begin
				repeat (12)
					write_reg({(1'($urandom) ? 4'hE : 4'hD), 10'h000, 2'($urandom)},
						8'($urandom));
				for (k = 0; k < 8; k++)
					drive_ppu({1'b0, 3'(k), 10'($urandom)});
				set_mapper(map_swapped);
			end
			end_test("chr banks", e0);

			// ---- mirroring ----
			e0 = errors;
			for (k = 0; k < 4; k++)
			begin
				write_reg(reg_mir, {4'($urandom), 2'(k), 2'($urandom)});
				for (n = 0; n < 8; n++)
				begin
					sel = 3'(n);
					r   = 11'($urandom);
					drive_ppu({sel[2], r[10], sel[1], sel[0], r[9:0]});
				end
			end
			end_test("mirroring", e0);

			// irq counter, one wrap then ack with a clear.
			e0 = errors;
			set_mapper(8'd24);
			latch = 8'($urandom);
			write_reg(reg_irq_latch, latch);
			write_reg(reg_irq_ctrl, 8'h02);
			n = 0;
			while (!irq && n < 300)
			begin
				@(posedge m2);
				n++;
			end
			if (!irq)
			begin
				errors++;
				$display("irq did not rise within 300 cycles of the control write");
			end
			else
				check_edge("irq_edge", n, 256 - int'(latch));
			write_reg(reg_irq_ack, 8'h00);
			check_bit("irq", irq, 1'b0);
			n = 0;
			while (!irq && n < 300)
			begin
				@(posedge m2);
				n++;
			end
			check_bit("irq", irq, 1'b0);
			end_test("irq counter", e0);

			// ---- pulse channels in constant mode ----
			e0 = errors;
			v1 = 4'($urandom);
			v2 = 4'($urandom);
			write_reg(reg_pulse1, {1'b1, 3'($urandom), v1});
			write_reg(reg_pulse1 + 16'd1, 8'($urandom));
			write_reg(reg_pulse1 + 16'd2, {4'h8, 4'($urandom)});
			write_reg(reg_pulse2, {1'b1, 3'($urandom), v2});
			write_reg(reg_pulse2 + 16'd1, 8'($urandom));
			write_reg(reg_pulse2 + 16'd2, {4'h8, 4'($urandom)});
			idle(4);
			check_snd("snd", snd, {5'({1'b0, v1} + {1'b0, v2}), 11'd0});
			write_reg(reg_pulse2 + 16'd2, 8'h00);
			idle(4);
			check_snd("snd", snd, {1'b0, v1, 11'd0});
			end_test("pulse sound", e0);

			$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
				tests_run, tests_failed, checks, errors);
			if (errors == 0)
				$display("ALL TESTS PASSED");
			else
				$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule

//--- compile.f
logic/vrc_bus_pkg.sv
logic/vrc_regmap_pkg.sv
logic/vrc_reg_decode.sv
logic/vrc_addr_map.sv
logic/vrc_irq.sv
logic/vrc_pulse.sv
logic/vrc_mapper.sv
testbench/tb_clock.sv
testbench/vrc_tb.sv

//--- Makefile
TOP = vrc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module vrc_mapper

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
